// File: build.f
logic/frame_pkg.sv
logic/port_arbiter.sv
logic/frame_ram.sv
logic/frame_capture.sv
logic/gray_copy.sv
logic/host_reader.sv
logic/frame_grab_top.sv
testbench/frame_grab_assert.sv
testbench/tb_frame_grab.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       := tb_frame_grab
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Simulation passed

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_frame_grab.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_grab;

    import frame_pkg::*;

    localparam int    FRAME_WORDS = 32;
    localparam addr_t GRAY_BASE   = 10'd512;
    localparam int    LINE_PIXELS = 8;
    localparam int    LINES       = 4;
    localparam int    WAIT_LIMIT  = 2000;
    localparam int    SEED        = 32'h6717a2c3;

    logic      clk = 1'b0;
    logic      reset_i;
    video_t    video_i;
    logic      capture_i;
    logic      capture_done_o;
    logic      copy_done_o;
    logic      host_kick_i;
    host_req_t host_req_i;
    logic      host_busy_o;
    word_t     host_data_o;
    logic      host_valid_o;

    int    errors        = 0;
    int    timeouts      = 0;
    int    capture_count = 0;
    int    copy_count    = 0;
    int    copy_mark     = 0;
    word_t sent_frame   [FRAME_WORDS];
    word_t model_frame  [FRAME_WORDS];
    word_t expect_words [FRAME_WORDS];

    frame_grab_top #(
        .FRAME_WORDS (FRAME_WORDS),
        .GRAY_BASE   (GRAY_BASE)
    ) i_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .video_i        (video_i),
        .capture_i      (capture_i),
        .capture_done_o (capture_done_o),
        .copy_done_o    (copy_done_o),
        .host_kick_i    (host_kick_i),
        .host_req_i     (host_req_i),
        .host_busy_o    (host_busy_o),
        .host_data_o    (host_data_o),
        .host_valid_o   (host_valid_o)
    );

    always #20 clk = ~clk;

    // Done pulse counters
    always @(negedge clk) begin
        if (capture_done_o) begin
            capture_count++;
        end
        if (copy_done_o) begin
            copy_count++;
        end
    end

    // Gray word with (r + 2g + b) >> 2 in each lower byte
    function automatic word_t gray_of(word_t px);
        int         sum;
        logic [7:0] y;
        sum = int'(px[23:16]) + 2 * int'(px[15:8]) + int'(px[7:0]);
        y   = 8'(sum >> 2);
        return {8'h00, y, y, y};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic vsync_pulse();
        repeat (2) begin
            @(posedge clk);
            video_i <= '{pixel: '0, de: 1'b0, vsync: 1'b1};
        end
        repeat (2) begin
            @(posedge clk);
            video_i <= '0;
        end
    endtask

    // Opening vsync then 4 lines of 8 pixels with blanking and a closing vsync
    task automatic drive_frame();
        int n;
        n = 0;
        vsync_pulse();
        for (int line = 0; line < LINES; line++) begin
            for (int x = 0; x < LINE_PIXELS; x++) begin
                sent_frame[n] = {8'h00, 24'($urandom)};
                @(posedge clk);
                video_i <= '{pixel: pixel_t'(sent_frame[n][23:0]), de: 1'b1, vsync: 1'b0};
                n++;
            end
            repeat (3) begin
                @(posedge clk);
                video_i <= '0;
            end
        end
        vsync_pulse();
    endtask

    task automatic arm_capture();
        @(posedge clk);
        capture_i <= 1'b1;
        @(posedge clk);
        capture_i <= 1'b0;
    endtask

    task automatic wait_pulse(input bit copy, input int base);
        int cycles;
        cycles = 0;
        while ((copy ? copy_count : capture_count) <= base && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if ((copy ? copy_count : capture_count) <= base) begin
            $display("Timeout waiting for %s", copy ? "copy_done_o" : "capture_done_o");
            errors++;
            timeouts++;
        end
    endtask

    task automatic read_and_check(input addr_t base, input int num, input string what);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        @(negedge clk);
        while (host_busy_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (host_busy_o) begin
            $display("Timeout waiting for the host port to become idle (%s)", what);
            errors++;
            timeouts++;
        end
        @(posedge clk);
        host_kick_i <= 1'b1;
        host_req_i  <= '{addr: base, num: count_t'(num)};
        @(posedge clk);
        host_kick_i <= 1'b0;
        @(negedge clk);
        check_bit("host_busy_o", host_busy_o, 1'b1);
        cycles = 0;
        while (got < num && cycles < WAIT_LIMIT) begin
            if (host_valid_o) begin
                if (host_data_o !== expect_words[got]) begin
                    $display("FAIL %s host_data_o word %0d: got %h, expected %h",
                             what, got, host_data_o, expect_words[got]);
                    errors++;
                end
                got++;
            end
            @(negedge clk);
            cycles++;
        end
        if (got < num) begin
            $display("Timeout in %s read, %0d of %0d words returned", what, got, num);
            errors++;
            timeouts++;
        end
        cycles = 0;
        while (host_busy_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (host_busy_o) begin
            $display("Host port stayed busy after the %s read", what);
            errors++;
            timeouts++;
        end
    endtask

    task automatic reset_outputs_low();
        @(negedge clk);
        check_bit("capture_done_o", capture_done_o, 1'b0);
        check_bit("copy_done_o", copy_done_o, 1'b0);
        check_bit("host_busy_o", host_busy_o, 1'b0);
        check_bit("host_valid_o", host_valid_o, 1'b0);
    endtask

    task automatic capture_armed_frame();
        int base;
        base = capture_count;
        drive_frame();
        if (capture_count != base) begin
            $display("capture_done_o pulsed for a frame driven before arming");
            errors++;
        end
        copy_mark = copy_count;
        arm_capture();
        drive_frame();
        wait_pulse(1'b0, base);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            model_frame[i]  = sent_frame[i];
            expect_words[i] = model_frame[i];
        end
        read_and_check(CAPTURE_BASE, FRAME_WORDS, "capture");
    endtask

    task automatic copy_to_gray();
        wait_pulse(1'b1, copy_mark);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            expect_words[i] = gray_of(model_frame[i]);
        end
        read_and_check(GRAY_BASE, FRAME_WORDS, "gray");
    endtask

    task automatic ignore_unarmed_frame();
        int cap_base;
        int copy_base;
        cap_base  = capture_count;
        copy_base = copy_count;
        drive_frame();
        repeat (10) @(posedge clk);
        if (capture_count != cap_base || copy_count != copy_base) begin
            $display("A frame without arming produced a done pulse");
            errors++;
        end
        for (int i = 0; i < FRAME_WORDS; i++) begin
            expect_words[i] = model_frame[i];
        end
        read_and_check(CAPTURE_BASE, FRAME_WORDS, "unarmed");
    endtask

    // Host read competes with the copy engine on the read port
    task automatic read_during_copy();
        int cap_base;
        cap_base  = capture_count;
        copy_mark = copy_count;
        arm_capture();
        drive_frame();
        wait_pulse(1'b0, cap_base);
        if (copy_count != copy_mark) begin
            $display("Gray copy finished before the contended host read started");
            errors++;
        end
        for (int i = 0; i < FRAME_WORDS; i++) begin
            model_frame[i]  = sent_frame[i];
            expect_words[i] = model_frame[i];
        end
        read_and_check(CAPTURE_BASE, FRAME_WORDS, "contended");
        wait_pulse(1'b1, copy_mark);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            expect_words[i] = gray_of(model_frame[i]);
        end
        read_and_check(GRAY_BASE, FRAME_WORDS, "second gray");
    endtask

    initial begin
        void'($urandom(SEED));
        reset_i     = 1'b1;
        video_i     = '0;
        capture_i   = 1'b0;
        host_kick_i = 1'b0;
        host_req_i  = '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        reset_outputs_low();
        capture_armed_frame();
        copy_to_gray();
        ignore_unarmed_frame();
        read_during_copy();

        repeat (4) @(posedge clk);
        errors += i_dut.u_checks.assert_fails;
        $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, i_dut.u_checks.assert_fails);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/frame_grab_assert.sv
`timescale 1ns/1ps
`default_nettype none

module frame_grab_assert (
    input wire       clk,
    input wire       reset_i,
    input wire       capture_done_o,
    input wire       copy_done_o,
    input wire       host_busy_o,
    input wire       host_valid_o,
    input wire [1:0] wr_gnt
);

    int assert_fails = 0;

    capture_done_single: assert property (@(posedge clk) disable iff (reset_i)
        capture_done_o |=> !capture_done_o)
    else begin
        $error("capture_done_o held for more than one cycle");
        assert_fails++;
    end

    copy_done_single: assert property (@(posedge clk) disable iff (reset_i)
        copy_done_o |=> !copy_done_o)
    else begin
        $error("copy_done_o held for more than one cycle");
        assert_fails++;
    end

    // Valid words only inside a busy host transfer
    valid_while_busy: assert property (@(posedge clk) disable iff (reset_i)
        host_valid_o |-> host_busy_o)
    else begin
        $error("host_valid_o set while host_busy_o is low");
        assert_fails++;
    end

    wr_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(wr_gnt))
    else begin
        $error("write arbiter granted more than one requester");
        assert_fails++;
    end

endmodule

bind frame_grab_top frame_grab_assert u_checks (
    .clk            (clk),
    .reset_i        (reset_i),
    .capture_done_o (capture_done_o),
    .copy_done_o    (copy_done_o),
    .host_busy_o    (host_busy_o),
    .host_valid_o   (host_valid_o),
    .wr_gnt         (wr_gnt)
);

`default_nettype wire

// File: logic/frame_grab_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_grab_top #(
    parameter int               FRAME_WORDS = 32,
    parameter frame_pkg::addr_t GRAY_BASE   = 10'd512
) (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire frame_pkg::video_t    video_i,
    input  wire                       capture_i,
    output wire                       capture_done_o,
    output wire                       copy_done_o,
    input  wire                       host_kick_i,
    input  wire frame_pkg::host_req_t host_req_i,
    output wire                       host_busy_o,
    output wire frame_pkg::word_t     host_data_o,
    output wire                       host_valid_o
);

    import frame_pkg::*;

    // Write port serves the grabber at 0 and the copy engine at 1
    wire [1:0]    wr_req;
    wire [1:0]    wr_gnt;
    wire mem_wr_t wr_payload [2];
    wire          wr_valid;
    wire mem_wr_t wr_sel;

    // Read port serves the copy engine at 0 and the host reader at 1
    wire [1:0]    rd_req;
    wire [1:0]    rd_gnt;
    wire mem_rd_t rd_payload [2];
    wire          rd_valid;
    wire mem_rd_t rd_sel;
    wire word_t   rd_data;

    frame_capture u_frame_capture (
        .clk            (clk),
        .reset_i        (reset_i),
        .video_i        (video_i),
        .capture_i      (capture_i),
        .wr_req_o       (wr_req[0]),
        .wr_o           (wr_payload[0]),
        .capture_done_o (capture_done_o)
    );

    gray_copy #(
        .FRAME_WORDS (FRAME_WORDS),
        .READ_BASE   (CAPTURE_BASE),
        .WRITE_BASE  (GRAY_BASE)
    ) u_gray_copy (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (capture_done_o),
        .rd_req_o  (rd_req[0]),
        .rd_o      (rd_payload[0]),
        .rd_gnt_i  (rd_gnt[0]),
        .rd_data_i (rd_data),
        .wr_req_o  (wr_req[1]),
        .wr_o      (wr_payload[1]),
        .wr_gnt_i  (wr_gnt[1]),
        .done_o    (copy_done_o)
    );

    host_reader u_host_reader (
        .clk       (clk),
        .reset_i   (reset_i),
        .kick_i    (host_kick_i),
        .req_i     (host_req_i),
        .busy_o    (host_busy_o),
        .rd_req_o  (rd_req[1]),
        .rd_o      (rd_payload[1]),
        .rd_gnt_i  (rd_gnt[1]),
        .rd_data_i (rd_data),
        .data_o    (host_data_o),
        .valid_o   (host_valid_o)
    );

    port_arbiter #(.req_t(mem_wr_t), .N(2)) u_wr_arbiter (
        .req_i     (wr_req),
        .payload_i (wr_payload),
        .gnt_o     (wr_gnt),
        .valid_o   (wr_valid),
        .payload_o (wr_sel)
    );

    port_arbiter #(.req_t(mem_rd_t), .N(2)) u_rd_arbiter (
        .req_i     (rd_req),
        .payload_i (rd_payload),
        .gnt_o     (rd_gnt),
        .valid_o   (rd_valid),
        .payload_o (rd_sel)
    );

    frame_ram #(.DEPTH(1 << ADDR_W)) u_frame_ram (
        .clk       (clk),
        .wr_en_i   (wr_valid),
        .wr_i      (wr_sel),
        .rd_en_i   (rd_valid),
        .rd_i      (rd_sel),
        .rd_data_o (rd_data)
    );

endmodule

`default_nettype wire

// File: logic/host_reader.sv
`timescale 1ns/1ps
`default_nettype none

module host_reader (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire                       kick_i,
    input  wire frame_pkg::host_req_t req_i,
    output logic                      busy_o,
    output logic                      rd_req_o,
    output frame_pkg::mem_rd_t        rd_o,
    input  wire                       rd_gnt_i,
    input  wire frame_pkg::word_t     rd_data_i,
    output frame_pkg::word_t          data_o,
    output logic                      valid_o
);

    import frame_pkg::*;

    addr_t  issue_addr_q;
    count_t num_q;
    count_t issued_q;
    count_t returned_q;
    logic   rd_gnt_q;

    assign rd_req_o  = busy_o && (issued_q != num_q);
    assign rd_o.addr = issue_addr_q;
    // Delayed grant marks our word on the shared read bus
    assign valid_o   = rd_gnt_q;
    assign data_o    = rd_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_o     <= 1'b0;
            rd_gnt_q   <= 1'b0;
            issued_q   <= '0;
            returned_q <= '0;
        end else begin
            rd_gnt_q <= rd_gnt_i;
            if (!busy_o && kick_i) begin
                busy_o       <= (req_i.num != '0);
                issue_addr_q <= req_i.addr;
                num_q        <= req_i.num;
                issued_q     <= '0;
                returned_q   <= '0;
            end else if (busy_o) begin
                if (rd_gnt_i) begin
                    issue_addr_q <= issue_addr_q + 1'b1;
                    issued_q     <= issued_q + 1'b1;
                end
                if (rd_gnt_q) begin
                    returned_q <= returned_q + 1'b1;
                    if (returned_q == num_q - 1'b1) begin
                        busy_o <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/gray_copy.sv
`timescale 1ns/1ps
`default_nettype none

module gray_copy #(
    parameter int               FRAME_WORDS = 32,
    parameter frame_pkg::addr_t READ_BASE   = frame_pkg::CAPTURE_BASE,
    parameter frame_pkg::addr_t WRITE_BASE  = 10'd512
) (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   start_i,
    output logic                  rd_req_o,
    output frame_pkg::mem_rd_t    rd_o,
    input  wire                   rd_gnt_i,
    input  wire frame_pkg::word_t rd_data_i,
    output logic                  wr_req_o,
    output frame_pkg::mem_wr_t    wr_o,
    input  wire                   wr_gnt_i,
    output logic                  done_o
);

    import frame_pkg::*;

    typedef enum logic [1:0] {
        ST_READ,
        ST_WAIT,
        ST_WRITE
    } state_t;

    state_t     state_q;
    logic       busy_q;
    addr_t      idx_q;
    logic       last;
    pixel_t     src;
    logic [9:0] luma_sum;
    pixel_t     gray_px;
    word_t      gray_word_q;

    assign last = (idx_q == addr_t'(FRAME_WORDS - 1));

    // Gray is (r + 2g + b) / 4 in all three colour bytes
    assign src      = rd_data_i[23:0];
    assign luma_sum = {2'b00, src.r} + {1'b0, src.g, 1'b0} + {2'b00, src.b};
    assign gray_px  = '{r: luma_sum[9:2], g: luma_sum[9:2], b: luma_sum[9:2]};

    assign rd_req_o  = busy_q && (state_q == ST_READ);
    assign rd_o.addr = READ_BASE + idx_q;
    assign wr_req_o  = busy_q && (state_q == ST_WRITE);
    assign wr_o.addr = WRITE_BASE + idx_q;
    assign wr_o.data = gray_word_q;
    assign done_o    = wr_req_o & wr_gnt_i & last;

    // Read data is on the bus the cycle after our grant
    always_ff @(posedge clk) begin
        if (busy_q && (state_q == ST_WAIT)) begin
            gray_word_q <= pixel_word(gray_px);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            state_q <= ST_READ;
            idx_q   <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q  <= 1'b1;
                state_q <= ST_READ;
                idx_q   <= '0;
            end
        end else begin
            case (state_q)
                ST_READ: begin
                    if (rd_gnt_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    state_q <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (wr_gnt_i) begin
                        state_q <= ST_READ;
                        idx_q   <= idx_q + 1'b1;
                        busy_q  <= !last;
                    end
                end
                default: begin
                    state_q <= ST_READ;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire frame_pkg::video_t video_i,
    input  wire                    capture_i,
    output logic                   wr_req_o,
    output frame_pkg::mem_wr_t     wr_o,
    output logic                   capture_done_o
);

    import frame_pkg::*;

    logic  vsync_q;
    logic  vsync_rise;
    logic  armed_q;
    logic  active_q;
    addr_t addr_q;

    assign vsync_rise = video_i.vsync & ~vsync_q;

    // Index 0 on the write port always wins since video cannot stall
    assign wr_req_o  = active_q & video_i.de;
    assign wr_o.addr = addr_q;
    assign wr_o.data = pixel_word(video_i.pixel);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vsync_q        <= 1'b0;
            armed_q        <= 1'b0;
            active_q       <= 1'b0;
            addr_q         <= CAPTURE_BASE;
            capture_done_o <= 1'b0;
        end else begin
            vsync_q        <= video_i.vsync;
            capture_done_o <= 1'b0;
            if (vsync_rise) begin
                if (active_q) begin
                    // Closing vsync ends the frame
                    active_q       <= 1'b0;
                    armed_q        <= 1'b0;
                    capture_done_o <= 1'b1;
                end else if (armed_q) begin
                    active_q <= 1'b1;
                    addr_q   <= CAPTURE_BASE;
                end
            end
            if (wr_req_o) begin
                addr_q <= addr_q + 1'b1;
            end
            if (capture_i) begin
                armed_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ram #(
    parameter int DEPTH = 1024
) (
    input  wire                     clk,
    input  wire                     wr_en_i,
    input  wire frame_pkg::mem_wr_t wr_i,
    input  wire                     rd_en_i,
    input  wire frame_pkg::mem_rd_t rd_i,
    output frame_pkg::word_t        rd_data_o
);

    import frame_pkg::*;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        // One cycle read latency
        if (rd_en_i) begin
            rd_data_o <= mem[rd_i.addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter #(
    parameter type req_t = logic,
    parameter int  N     = 2
) (
    input  wire [N-1:0] req_i,
    input  wire req_t   payload_i [N],
    output logic [N-1:0] gnt_o,
    output logic        valid_o,
    output req_t        payload_o
);

    assign valid_o = |req_i;

    // Walk downwards so the lowest requesting index is left standing
    always_comb begin
        gnt_o     = '0;
        payload_o = payload_i[0];
        for (int i = N - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                gnt_o     = '0;
                gnt_o[i]  = 1'b1;
                payload_o = payload_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_pkg.sv
`default_nettype none

package frame_pkg;

    localparam int ADDR_W = 10;
    localparam int WORD_W = 32;
    localparam int NUM_W  = 10;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [NUM_W-1:0]  count_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        pixel_t pixel;
        logic   de;
        logic   vsync;
    } video_t;

    // Write request payload
    typedef struct packed {
        addr_t addr;
        word_t data;
    } mem_wr_t;

    typedef struct packed {
        addr_t addr;
    } mem_rd_t;

    typedef struct packed {
        addr_t  addr;
        count_t num;
    } host_req_t;

    localparam addr_t CAPTURE_BASE = '0;

    // Top byte zero, then r, g, b
    function automatic word_t pixel_word(pixel_t px);
        return {8'h00, px};
    endfunction

endpackage

`default_nettype wire
